/* compile.f */
hdl/lsu_pkg.sv
hdl/axi_lite_pkg.sv
hdl/simple_dpram_sclk.sv
hdl/store_buffer.sv
hdl/store_drain_axi.sv
hdl/store_unit_top.sv
test/axi_lite_mem_model.sv
test/store_unit_properties.sv
test/store_unit_tb.sv

/* Bender.yml */
package:
  name: store_unit

sources:
  # RTL, in compile order.
  - files:
      - hdl/lsu_pkg.sv
      - hdl/axi_lite_pkg.sv
      - hdl/simple_dpram_sclk.sv
      - hdl/store_buffer.sv
      - hdl/store_drain_axi.sv
      - hdl/store_unit_top.sv
  # Testbench, top module store_unit_tb.
  - target: test
    files:
      - test/axi_lite_mem_model.sv
      - test/store_unit_properties.sv
      - test/store_unit_tb.sv

/* test/store_unit_tb.sv */
//****************************************
// Testbench for the store path. Random stores go into the DUT, every
// AXI write is scoreboarded and error reports are checked.
//****************************************
`timescale 1ns/1ns
`default_nettype none

module store_unit_tb;

   import lsu_pkg::*;
   import axi_lite_pkg::*;

   localparam int          OW              = OPERAND_WIDTH_DEFAULT;
   localparam int          DW              = DEPTH_WIDTH_DEFAULT;
   localparam int          NUM_RANDOM      = 40;
   localparam int          FILL_COUNT      = (1 << DW) + 1; // Slots plus the entry in the engine.
   localparam int          NUM_ERROR       = 4;
   localparam int          NUM_STORES      = NUM_RANDOM + FILL_COUNT + NUM_ERROR;
   localparam int          WATCHDOG_CYCLES = NUM_STORES * 40 + 2000;
   localparam logic [31:0] SEED            = 32'h612eb2c6;

   typedef struct packed {
      logic [OW-1:0]   adr;
      logic [OW-1:0]   dat;
      logic [OW/8-1:0] bsel;
      logic [OW-1:0]   pc;
      logic            atomic;
   } store_t;

   logic clk, rst, write, atomic, full, empty, hold_aw;
   logic [OW-1:0] adr, dat, pc, awaddr, wdata, err_pc;
   logic [OW/8-1:0] bsel, wstrb;
   logic awvalid, awready, wvalid, wready, bvalid, bready, bus_err, err_atomic;
   logic [2:0] awprot;
   logic [1:0] bresp;

   store_t pending [$];   // Accepted stores not yet answered on B.
   store_t err_store;     // Store whose B handshake came last.
   logic   err_due = 1'b0; // bus_err_o expected on this cycle.

   store_unit_top #(.DEPTH_WIDTH(DW), .OPERAND_WIDTH(OW)) DUT (
      .clk(clk), .rst(rst), .write_i(write), .adr_i(adr), .dat_i(dat), .bsel_i(bsel),
      .pc_i(pc), .atomic_i(atomic), .full_o(full), .empty_o(empty),
      .awvalid_o(awvalid), .awready_i(awready), .awaddr_o(awaddr), .awprot_o(awprot),
      .wvalid_o(wvalid), .wready_i(wready), .wdata_o(wdata), .wstrb_o(wstrb),
      .bvalid_i(bvalid), .bready_o(bready), .bresp_i(bresp), .bus_err_o(bus_err),
      .err_pc_o(err_pc), .err_atomic_o(err_atomic));

   axi_lite_mem_model #(.ADDR_WIDTH(OW)) u_slave (
      .clk(clk), .rst(rst), .hold_aw_i(hold_aw), .awvalid_i(awvalid), .awready_o(awready),
      .awaddr_i(awaddr), .awprot_i(awprot), .wvalid_i(wvalid), .wready_o(wready),
      .bvalid_o(bvalid), .bready_i(bready), .bresp_o(bresp));

   //****************************************
   // Helpers
   //****************************************
   task automatic stop_with_fail(input string why);
      $display("%s", why);
      $display("RESULT: FAIL");
      $fatal(1, "Simulation stopped on the first error.");
   endtask

   task automatic report_mismatch(input string msg);
      stop_with_fail($sformatf("Mismatch at %0t ns: %s", $time, msg));
   endtask

   // The slave fails every write into 0x0000_F000 to 0x0000_FFFF.
   function automatic logic in_err_window(input logic [OW-1:0] a);
      return (a >= 32'h0000_F000) && (a <= 32'h0000_FFFF);
   endfunction

   function automatic store_t random_store(input logic want_err);
      store_t      s;
      logic [31:0] r;
      r        = $urandom;
      s.adr    = $urandom & 32'hFFFF_FFFC;       // Word aligned.
      if (want_err) s.adr = 32'h0000_F000 | (s.adr & 32'h0000_0FFC);
      else if (in_err_window(s.adr)) s.adr[12] = 1'b0; // Moves it down to 0xExxx.
      s.dat    = $urandom;
      s.bsel   = r[OW/8-1:0];
      s.pc     = $urandom & 32'hFFFF_FFFC;
      s.atomic = r[8];
      return s;
   endfunction

   // Called 1 ns after a rising edge, returns 1 ns after the accepting edge.
   task automatic push_store(input store_t s);
      while (full) begin
         @(posedge clk);
         #1;
      end
      {write, adr, dat, bsel, pc, atomic} = {1'b1, s};
      pending.push_back(s);
      @(posedge clk);
      #1 write = 1'b0;
   endtask

   task automatic wait_drained();
      while (pending.size() != 0) @(negedge clk);
      @(posedge clk);                             // Last B handshake, engine back in idle.
      #1;
      assert (empty) else report_mismatch("empty_o low after all stores completed");
   endtask

   //****************************************
   // Scoreboard, sampled mid-cycle
   //****************************************
   always @(negedge clk) begin
      if (!rst) begin
         assert (bus_err == err_due)
            else report_mismatch($sformatf("bus_err_o is %0b, expected %0b", bus_err, err_due));
         if (err_due) begin
            assert (err_pc == err_store.pc && err_atomic == err_store.atomic)
               else report_mismatch($sformatf("error pc %h/%0b, expected %h/%0b",
                  err_pc, err_atomic, err_store.pc, err_store.atomic));
         end
         err_due = 1'b0;
         if ((awvalid && awready) || (wvalid && wready) || (bvalid && bready)) begin
            if (pending.size() == 0) stop_with_fail("AXI handshake with no store pending.");
         end
         if (awvalid && awready) begin
            assert (awaddr == pending[0].adr && awprot == PROT_DATA)
               else report_mismatch($sformatf("AW %h prot %0d, expected %h prot %0d",
                  awaddr, awprot, pending[0].adr, PROT_DATA));
         end
         if (wvalid && wready) begin
            assert (wdata == pending[0].dat && wstrb == pending[0].bsel)
               else report_mismatch($sformatf("W %h/%h, expected %h/%h",
                  wdata, wstrb, pending[0].dat, pending[0].bsel));
         end
         if (bvalid && bready) begin
            err_store = pending.pop_front();
            err_due   = in_err_window(err_store.adr); // Pulse due on the next cycle.
         end
         if (DUT.u_store_drain.u_drain_props.fail_count != 0 ||
             DUT.u_store_buffer.u_buffer_props.fail_count != 0) begin
            stop_with_fail("A bound handshake or buffer property failed.");
         end
      end
   end

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      #(WATCHDOG_CYCLES * 10);
      stop_with_fail($sformatf("Timeout after %0d cycles, stores never drained.",
         WATCHDOG_CYCLES));
   end

   //****************************************
   // Stimulus
   //****************************************
   initial begin
      store_t s;
      void'($urandom(SEED));
      rst     = 1'b1;
      write   = 1'b0;
      adr     = '0;
      dat     = '0;
      bsel    = '0;
      pc      = '0;
      atomic  = 1'b0;
      hold_aw = 1'b0;
      repeat (3) @(posedge clk);
      #1 rst = 1'b0;
      @(negedge clk);
      assert (!awvalid && !wvalid && !bready && !bus_err && empty)
         else report_mismatch("outputs not in their reset state");
      @(posedge clk);
      #1;
      for (int i = 0; i < NUM_RANDOM; i++) begin
         push_store(random_store(($urandom % 5) == 0)); // About one store in five fails.
         repeat ($urandom % 3) begin
            @(posedge clk);
            #1;
         end
      end
      wait_drained();
      hold_aw = 1'b1;                              // Stall AW so the buffer fills up.
      for (int i = 0; i < FILL_COUNT; i++) begin
         assert (!full) else report_mismatch($sformatf("full_o high after %0d stores", i));
         push_store(random_store(1'b0));
      end
      @(negedge clk);
      assert (full) else report_mismatch($sformatf("full_o low after %0d stores", FILL_COUNT));
      @(posedge clk);
      #1 hold_aw = 1'b0;
      wait_drained();
      for (int i = 0; i < NUM_ERROR; i++) begin
         s        = random_store(1'b1);
         s.atomic = i[0];                          // Alternate the atomic flag.
         push_store(s);
      end
      wait_drained();
      @(negedge clk);                              // Let the last error pulse be checked.
      #1;
      if (pending.size() != 0 || !empty) begin
         stop_with_fail("Stores were left in the DUT at the end of the run.");
      end else begin
         $display("RESULT: PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* test/store_unit_properties.sv */
//****************************************
// Concurrent checks on the AXI handshakes of the drain engine and on
// the full flag of the store buffer. Attached to both modules by bind.
//****************************************
`timescale 1ns/1ns
`default_nettype none

module store_unit_properties #(
   parameter int OPERAND_WIDTH = lsu_pkg::OPERAND_WIDTH_DEFAULT
) (
   input logic                       clk,
   input logic                       rst,
   input logic                       awvalid_i,
   input logic                       awready_i,
   input logic [OPERAND_WIDTH-1:0]   awaddr_i,
   input logic                       wvalid_i,
   input logic                       wready_i,
   input logic [OPERAND_WIDTH-1:0]   wdata_i,
   input logic [OPERAND_WIDTH/8-1:0] wstrb_i,
   input logic                       bvalid_i,
   input logic                       bready_i,
   input logic                       write_i,
   input logic                       full_i
);

   int unsigned fail_count = 0;  // Read by the testbench.

   //****************************************
   // AXI4-Lite handshakes
   //****************************************
   a_aw_hold: assert property (@(posedge clk) disable iff (rst)
      awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
      else begin
         fail_count++;
         $error("AW dropped or changed before awready.");
      end
   a_w_hold: assert property (@(posedge clk) disable iff (rst)
      wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i) && $stable(wstrb_i))
      else begin
         fail_count++;
         $error("W dropped or changed before wready.");
      end
   a_b_hold: assert property (@(posedge clk) disable iff (rst)
      bready_i && !bvalid_i |=> bready_i)
      else begin
         fail_count++;
         $error("bready dropped before bvalid.");
      end

   //****************************************
   // Buffer flags
   //****************************************
   a_no_write_full: assert property (@(posedge clk) disable iff (rst) !(write_i && full_i))
      else begin
         fail_count++;
         $error("Store written while the buffer was full.");
      end

endmodule

// Unused ports are tied off, so those checks hold trivially in that instance.
bind store_drain_axi store_unit_properties #(.OPERAND_WIDTH(OPERAND_WIDTH)) u_drain_props (
   .clk(clk), .rst(rst), .awvalid_i(awvalid_o), .awready_i(awready_i),
   .awaddr_i(awaddr_o), .wvalid_i(wvalid_o), .wready_i(wready_i), .wdata_i(wdata_o),
   .wstrb_i(wstrb_o), .bvalid_i(bvalid_i), .bready_i(bready_o),
   .write_i(1'b0), .full_i(1'b0));

bind store_buffer store_unit_properties #(.OPERAND_WIDTH(OPERAND_WIDTH)) u_buffer_props (
   .clk(clk), .rst(rst), .awvalid_i(1'b0), .awready_i(1'b0), .awaddr_i('0),
   .wvalid_i(1'b0), .wready_i(1'b0), .wdata_i('0), .wstrb_i('0), .bvalid_i(1'b0),
   .bready_i(1'b0), .write_i(write_i), .full_i(full_o));

`default_nettype wire

/* test/axi_lite_mem_model.sv */
//****************************************
// AXI4-Lite write slave for the testbench. Ready and response timing
// stall at random, and writes into the error window fail.
//****************************************
`timescale 1ns/1ns
`default_nettype none

module axi_lite_mem_model #(
   parameter int ADDR_WIDTH = lsu_pkg::OPERAND_WIDTH_DEFAULT
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  hold_aw_i,  // Forces awready low for the fill test.
   input  logic                  awvalid_i,
   output logic                  awready_o,
   input  logic [ADDR_WIDTH-1:0] awaddr_i,
   input  logic [2:0]            awprot_i,
   input  logic                  wvalid_i,
   output logic                  wready_o,
   output logic                  bvalid_o,
   input  logic                  bready_i,
   output logic [1:0]            bresp_o
);

   import axi_lite_pkg::*;

   logic                  aw_got;     // Address phase of the current write is done.
   logic                  w_got;      // Data phase of the current write is done.
   logic                  aw_go;      // Random permission to take AW this cycle.
   logic                  w_go;       // Random permission to take W this cycle.
   logic                  b_go;       // Random permission to answer this cycle.
   logic [ADDR_WIDTH-1:0] addr_q;
   logic [2:0]            prot_q;

   // One write at a time, so a taken channel stays closed until B is done.
   assign awready_o = aw_go && !aw_got && !hold_aw_i;
   assign wready_o  = w_go && !w_got;  // The data beat is taken and dropped.

   // Error window 0x0000_F000 to 0x0000_FFFF, DECERR in its upper half.
   function automatic logic [1:0] resp_for(input logic [ADDR_WIDTH-1:0] addr,
                                           input logic [2:0] prot);
      if (addr[ADDR_WIDTH-1:12] == 'h0000F) begin
         return addr[11] ? RESP_DECERR : RESP_SLVERR;
      end
      return (prot == PROT_DATA) ? RESP_OKAY : RESP_SLVERR; // Wrong AWPROT is refused.
   endfunction

   always_ff @(posedge clk) begin
      if (rst) begin
         {aw_got, w_got, aw_go, w_go, b_go} <= '0;
         bvalid_o <= 1'b0;
         bresp_o  <= RESP_OKAY;
      end else begin
         aw_go <= ($urandom % 4) != 0;          // About one stall cycle in four.
         w_go  <= ($urandom % 4) != 0;
         b_go  <= ($urandom % 3) != 0;
         if (awvalid_i && awready_o) begin
            aw_got <= 1'b1;
            addr_q <= awaddr_i;
            prot_q <= awprot_i;
         end
         if (wvalid_i && wready_o) begin
            w_got <= 1'b1;
         end
         if (aw_got && w_got && !bvalid_o && b_go) begin
            bvalid_o <= 1'b1;                   // Both phases seen, answer now.
            bresp_o  <= resp_for(addr_q, prot_q);
         end
         if (bvalid_o && bready_i) begin
            bvalid_o <= 1'b0;                   // Response taken, open both channels again.
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/store_unit_top.sv */
//****************************************
// Store path of the LSU. Committed stores enter the buffer and
// leave in order as AXI4-Lite writes through the drain engine.
//****************************************
`timescale 1ns/1ns
`default_nettype none

module store_unit_top #(
   parameter int DEPTH_WIDTH   = lsu_pkg::DEPTH_WIDTH_DEFAULT,
   parameter int OPERAND_WIDTH = lsu_pkg::OPERAND_WIDTH_DEFAULT
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       write_i,
   input  logic [OPERAND_WIDTH-1:0]   adr_i,
   input  logic [OPERAND_WIDTH-1:0]   dat_i,
   input  logic [OPERAND_WIDTH/8-1:0] bsel_i,
   input  logic [OPERAND_WIDTH-1:0]   pc_i,
   input  logic                       atomic_i,
   output logic                       full_o,
   output logic                       empty_o,
   output logic                       awvalid_o,
   input  logic                       awready_i,
   output logic [OPERAND_WIDTH-1:0]   awaddr_o,
   output logic [2:0]                 awprot_o,
   output logic                       wvalid_o,
   input  logic                       wready_i,
   output logic [OPERAND_WIDTH-1:0]   wdata_o,
   output logic [OPERAND_WIDTH/8-1:0] wstrb_o,
   input  logic                       bvalid_i,
   output logic                       bready_o,
   input  logic [1:0]                 bresp_i,
   output logic                       bus_err_o,
   output logic [OPERAND_WIDTH-1:0]   err_pc_o,
   output logic                       err_atomic_o
);

   // Entry from the buffer to the drain engine.
   logic [OPERAND_WIDTH-1:0]   sb_adr;
   logic [OPERAND_WIDTH-1:0]   sb_dat;
   logic [OPERAND_WIDTH/8-1:0] sb_bsel;
   logic [OPERAND_WIDTH-1:0]   sb_pc;
   logic                       sb_atomic;
   logic                       sb_read;  // Pop request from the drain engine.

   store_buffer #(
      .DEPTH_WIDTH   (DEPTH_WIDTH),
      .OPERAND_WIDTH (OPERAND_WIDTH)
   ) u_store_buffer (
      .clk      (clk),
      .rst      (rst),
      .pc_i     (pc_i),
      .adr_i    (adr_i),
      .dat_i    (dat_i),
      .bsel_i   (bsel_i),
      .atomic_i (atomic_i),
      .write_i  (write_i),
      .pc_o     (sb_pc),
      .adr_o    (sb_adr),
      .dat_o    (sb_dat),
      .bsel_o   (sb_bsel),
      .atomic_o (sb_atomic),
      .read_i   (sb_read),
      .full_o   (full_o),
      .empty_o  (empty_o)      // Also feeds the drain engine.
   );

   store_drain_axi #(
      .OPERAND_WIDTH (OPERAND_WIDTH)
   ) u_store_drain (
      .clk          (clk),
      .rst          (rst),
      .empty_i      (empty_o),
      .read_o       (sb_read),
      .adr_i        (sb_adr),
      .dat_i        (sb_dat),
      .bsel_i       (sb_bsel),
      .pc_i         (sb_pc),
      .atomic_i     (sb_atomic),
      .awvalid_o    (awvalid_o),
      .awready_i    (awready_i),
      .awaddr_o     (awaddr_o),
      .awprot_o     (awprot_o),
      .wvalid_o     (wvalid_o),
      .wready_i     (wready_i),
      .wdata_o      (wdata_o),
      .wstrb_o      (wstrb_o),
      .bvalid_i     (bvalid_i),
      .bready_o     (bready_o),
      .bresp_i      (bresp_i),
      .bus_err_o    (bus_err_o),
      .err_pc_o     (err_pc_o),
      .err_atomic_o (err_atomic_o)
   );

endmodule

`default_nettype wire

/* hdl/store_drain_axi.sv */
//****************************************
// Drain engine that pops stores in program order and writes each
// one over AXI4-Lite, one write outstanding. Error responses are
// reported with the pc and atomic flag of the failing store.
//****************************************
`timescale 1ns/1ns
`default_nettype none

module store_drain_axi #(
   parameter int OPERAND_WIDTH = lsu_pkg::OPERAND_WIDTH_DEFAULT
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       empty_i,
   output logic                       read_o,
   input  logic [OPERAND_WIDTH-1:0]   adr_i,
   input  logic [OPERAND_WIDTH-1:0]   dat_i,
   input  logic [OPERAND_WIDTH/8-1:0] bsel_i,
   input  logic [OPERAND_WIDTH-1:0]   pc_i,
   input  logic                       atomic_i,
   output logic                       awvalid_o,
   input  logic                       awready_i,
   output logic [OPERAND_WIDTH-1:0]   awaddr_o,
   output logic [2:0]                 awprot_o,
   output logic                       wvalid_o,
   input  logic                       wready_i,
   output logic [OPERAND_WIDTH-1:0]   wdata_o,
   output logic [OPERAND_WIDTH/8-1:0] wstrb_o,
   input  logic                       bvalid_i,
   output logic                       bready_o,
   input  logic [1:0]                 bresp_i,
   output logic                       bus_err_o,
   output logic [OPERAND_WIDTH-1:0]   err_pc_o,
   output logic                       err_atomic_o
);

   import axi_lite_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,   // Waiting for a queued store.
      ST_FETCH,  // RAM output is valid, capture it.
      ST_SEND,   // AW and W in flight.
      ST_RESP    // Waiting on the B channel.
   } state_t;

   state_t                     state_q;   // Current FSM state.
   logic [OPERAND_WIDTH-1:0]   adr_q;     // Captured store address.
   logic [OPERAND_WIDTH-1:0]   dat_q;     // Captured store data.
   logic [OPERAND_WIDTH/8-1:0] bsel_q;    // Captured byte selects.
   logic [OPERAND_WIDTH-1:0]   pc_q;      // Captured pc of the store.
   logic                       atomic_q;  // Captured atomic flag.
   logic                       aw_left;   // AW still waits for awready after this edge.
   logic                       w_left;    // W still waits for wready after this edge.
   logic                       b_done;    // B handshake in this cycle.
   logic                       b_error;   // Response code is an error.

   assign read_o  = (state_q == ST_IDLE) && !empty_i; // Pop only when idle.
   assign aw_left = awvalid_o && !awready_i;
   assign w_left  = wvalid_o && !wready_i;
   assign b_done  = bready_o && bvalid_i;
   assign b_error = (bresp_i == RESP_SLVERR) || (bresp_i == RESP_DECERR);

   assign awaddr_o = adr_q;               // Payloads come straight from the entry.
   assign awprot_o = PROT_DATA;
   assign wdata_o  = dat_q;
   assign wstrb_o  = bsel_q;

   //****************************************
   // FSM and channel control
   //****************************************
   always_ff @(posedge clk) begin
      if (rst) begin
         state_q   <= ST_IDLE;
         awvalid_o <= 1'b0;
         wvalid_o  <= 1'b0;
         bready_o  <= 1'b0;
         bus_err_o <= 1'b0;
      end else begin
         bus_err_o <= 1'b0;               // Error flag is a single-cycle pulse.
         case (state_q)
            ST_IDLE: begin
               if (read_o) begin
                  state_q <= ST_FETCH;    // Entry shows up on the next cycle.
               end
            end
            ST_FETCH: begin
               state_q   <= ST_SEND;
               awvalid_o <= 1'b1;         // Both channels start together.
               wvalid_o  <= 1'b1;
            end
            ST_SEND: begin
               awvalid_o <= aw_left;      // Each valid drops on its own ready.
               wvalid_o  <= w_left;
               if (!aw_left && !w_left) begin
                  state_q  <= ST_RESP;    // Both handshakes are done.
                  bready_o <= 1'b1;
               end
            end
            ST_RESP: begin
               if (b_done) begin
                  state_q   <= ST_IDLE;
                  bready_o  <= 1'b0;
                  bus_err_o <= b_error;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   //****************************************
   // Entry and error registers
   //****************************************
   always_ff @(posedge clk) begin
      if (state_q == ST_FETCH) begin
         adr_q    <= adr_i;               // Buffer outputs are valid in this state.
         dat_q    <= dat_i;
         bsel_q   <= bsel_i;
         pc_q     <= pc_i;
         atomic_q <= atomic_i;
      end
      if (b_done && b_error) begin
         err_pc_o     <= pc_q;            // Held until the next failing store.
         err_atomic_o <= atomic_q;
      end
   end

endmodule

`default_nettype wire

/* hdl/store_buffer.sv */
//****************************************
// In-order FIFO of committed stores on top of the dual-port RAM.
// The LSU writes entries, the drain engine reads them back.
//****************************************
`timescale 1ns/1ns
`default_nettype none

module store_buffer #(
   parameter int DEPTH_WIDTH   = lsu_pkg::DEPTH_WIDTH_DEFAULT,
   parameter int OPERAND_WIDTH = lsu_pkg::OPERAND_WIDTH_DEFAULT
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic [OPERAND_WIDTH-1:0]   pc_i,
   input  logic [OPERAND_WIDTH-1:0]   adr_i,
   input  logic [OPERAND_WIDTH-1:0]   dat_i,
   input  logic [OPERAND_WIDTH/8-1:0] bsel_i,
   input  logic                       atomic_i,
   input  logic                       write_i,
   output logic [OPERAND_WIDTH-1:0]   pc_o,
   output logic [OPERAND_WIDTH-1:0]   adr_o,
   output logic [OPERAND_WIDTH-1:0]   dat_o,
   output logic [OPERAND_WIDTH/8-1:0] bsel_o,
   output logic                       atomic_o,
   input  logic                       read_i,
   output logic                       full_o,
   output logic                       empty_o
);

   import lsu_pkg::*;

   localparam int ENTRY_WIDTH = store_entry_width(OPERAND_WIDTH); // One packed store.

   logic [ENTRY_WIDTH-1:0] ram_din;   // Packed entry going in.
   logic [ENTRY_WIDTH-1:0] ram_dout;  // Packed entry coming out.
   logic [DEPTH_WIDTH:0]   wr_ptr;    // Write pointer with wrap bit on top.
   logic [DEPTH_WIDTH:0]   rd_ptr;    // Read pointer with wrap bit on top.

   // Pack and unpack in the STORE_FIELDS order.
   assign ram_din = {adr_i, dat_i, bsel_i, pc_i, atomic_i};
   assign {adr_o, dat_o, bsel_o, pc_o, atomic_o} = ram_dout;

   //****************************************
   // Flags
   //****************************************
   // Same slot but one lap apart means every slot is taken.
   assign full_o  = (wr_ptr[DEPTH_WIDTH] != rd_ptr[DEPTH_WIDTH]) &&
                    (wr_ptr[DEPTH_WIDTH-1:0] == rd_ptr[DEPTH_WIDTH-1:0]);
   assign empty_o = (wr_ptr == rd_ptr);  // Equal pointers mean nothing is queued.

   //****************************************
   // Pointers
   //****************************************
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;                    // Start with an empty buffer.
      end else if (write_i) begin
         wr_ptr <= wr_ptr + 1'b1;         // The LSU never writes while full.
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_ptr <= '0;
      end else if (read_i) begin
         rd_ptr <= rd_ptr + 1'b1;         // The drain engine only reads while not empty.
      end
   end

   simple_dpram_sclk #(
      .ADDR_WIDTH    (DEPTH_WIDTH),
      .DATA_WIDTH    (ENTRY_WIDTH),
      .ENABLE_BYPASS (1)
   ) u_store_ram (
      .clk     (clk),
      .raddr_i (rd_ptr[DEPTH_WIDTH-1:0]),
      .re_i    (read_i),
      .waddr_i (wr_ptr[DEPTH_WIDTH-1:0]),
      .we_i    (write_i),
      .din_i   (ram_din),
      .dout_o  (ram_dout)
   );

endmodule

`default_nettype wire

/* hdl/simple_dpram_sclk.sv */
//****************************************
// Single-clock dual-port RAM with a registered read port.
// A same-address write can be forwarded to the read port.
//****************************************
`timescale 1ns/1ns
`default_nettype none

module simple_dpram_sclk #(
   parameter int ADDR_WIDTH    = 2,
   parameter int DATA_WIDTH    = 32,
   parameter int ENABLE_BYPASS = 1
) (
   input  logic                  clk,
   input  logic [ADDR_WIDTH-1:0] raddr_i,
   input  logic                  re_i,
   input  logic [ADDR_WIDTH-1:0] waddr_i,
   input  logic                  we_i,
   input  logic [DATA_WIDTH-1:0] din_i,
   output logic [DATA_WIDTH-1:0] dout_o
);

   localparam int DEPTH = 1 << ADDR_WIDTH; // Number of words in the array.

   logic [DATA_WIDTH-1:0] mem [DEPTH];    // Storage array.
   logic                  collide;        // Read and write hit the same word.

   // Forwarding only matters when both ports are active on one address.
   assign collide = (ENABLE_BYPASS != 0) && we_i && (waddr_i == raddr_i);

   //****************************************
   // Write port
   //****************************************
   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= din_i;            // Synchronous write.
      end
   end

   //****************************************
   // Read port
   //****************************************
   always_ff @(posedge clk) begin
      if (re_i) begin
         if (collide) begin
            dout_o <= din_i;               // New data wins over the stale word.
         end else begin
            dout_o <= mem[raddr_i];        // Normal registered read.
         end
      end
   end
   // dout_o holds its value while re_i is low.

endmodule

`default_nettype wire

/* hdl/axi_lite_pkg.sv */
//****************************************
// AXI4-Lite encodings used on the store write path.
// Response codes and the AWPROT value for data writes.
//****************************************
`default_nettype none

package axi_lite_pkg;

   //****************************************
   // Write response codes on BRESP.
   //****************************************
   localparam logic [1:0] RESP_OKAY   = 2'b00; // Normal access done.
   localparam logic [1:0] RESP_EXOKAY = 2'b01; // Exclusive access done.
   localparam logic [1:0] RESP_SLVERR = 2'b10; // Slave reported an error.
   localparam logic [1:0] RESP_DECERR = 2'b11; // No slave at this address.

   // Unprivileged, secure, data access.
   // Bit 0 privileged, bit 1 non-secure, bit 2 instruction.
   localparam logic [2:0] PROT_DATA = 3'b000;

endpackage

`default_nettype wire

/* hdl/lsu_pkg.sv */
//****************************************
// Sizing defaults of the load/store unit and the layout of one
// buffered store entry. Shared by the RTL and the testbench.
//****************************************
`default_nettype none

package lsu_pkg;

   localparam int OPERAND_WIDTH_DEFAULT = 32; // CPU word width in bits.
   localparam int DEPTH_WIDTH_DEFAULT   = 2;  // Log2 of the store buffer depth.

   //****************************************
   // The STORE_FIELDS order packs an entry MSB first as
   //   {address, data, byte selects, pc, atomic}
   // with three operand-wide fields, one select bit per byte and
   // one flag bit at the bottom.
   //****************************************

   // Width of one packed store entry for a given operand width.
   function automatic int store_entry_width(input int operand_width);
      return 3 * operand_width + operand_width / 8 + 1; // Matches STORE_FIELDS.
   endfunction

endpackage

`default_nettype wire
